//--- hw/z8_cfg.svh
`ifndef Z8_CFG_SVH
`define Z8_CFG_SVH

// first fetch after reset
`define Z8_RESET_PC 16'h000C

// general registers at 00..7F
`define Z8_REG_COUNT 128

// special registers
`define Z8_ADDR_FLAGS 8'hFC
`define Z8_ADDR_RP 8'hFD
`define Z8_ADDR_PORT2 8'h02

`endif

//--- hw/z8Pkg.sv
`default_nettype none

package z8Pkg;

    // two-operand ops are {1, opcode high nibble}, one-operand ops {0, high nibble}
    typedef enum logic [4:0] {
        aluDec  = 5'h00,
        aluInc  = 5'h02,
        aluCom  = 5'h06,
        aluLd   = 5'h07,
        aluClr  = 5'h0B,
        aluSwap = 5'h0F,
        aluAdd  = 5'h10,
        aluAdc  = 5'h11,
        aluSub  = 5'h12,
        aluSbc  = 5'h13,
        aluOr   = 5'h14,
        aluAnd  = 5'h15,
        aluTcm  = 5'h16,
        aluTm   = 5'h17,
        aluCp   = 5'h1A,
        aluXor  = 5'h1B
    } aluOpT;

    typedef enum logic [3:0] {
        fetchInstr,
        readInstr,
        wait2,
        read2,
        wait3,
        read3,
        decode,
        aluOne,
        aluTwo
    } cpuStateT;

    // bit positions in the flags byte
    typedef enum logic [2:0] {
        flagV = 3'd4,
        flagS = 3'd5,
        flagZ = 3'd6,
        flagC = 3'd7
    } flagIndexT;

endpackage

`default_nettype wire

//--- hw/z8Alu.sv
`timescale 1ns/100ps
`default_nettype none

module z8Alu
    import z8Pkg::*;
(
    input  aluOpT      aluOp,
    input  logic [7:0] a,
    input  logic [7:0] b,
    input  logic [7:0] flagsIn,
    output logic [7:0] result,
    output logic [7:0] flagsOut
);
    logic       carryIn;
    logic [8:0] sum;
    logic [8:0] diff;
    logic       updateZs;
    logic       clearV;

    // adc and sbc pull in the current carry
    assign carryIn = (aluOp == aluAdc || aluOp == aluSbc) ? flagsIn[flagC] : 1'b0;
    assign sum = {1'b0, a} + {1'b0, b} + 9'(carryIn);
    assign diff = {1'b0, a} - {1'b0, b} - 9'(carryIn);

    always_comb begin
        result = a;
        flagsOut = flagsIn;
        updateZs = 1'b1;
        clearV = 1'b0;
        case (aluOp)
            aluAdd, aluAdc: begin
                result = sum[7:0];
                flagsOut[flagC] = sum[8];
                flagsOut[flagV] = (a[7] == b[7]) && (sum[7] != a[7]);
            end
            aluSub, aluSbc, aluCp: begin
                // diff[8] is the borrow
                result = diff[7:0];
                flagsOut[flagC] = diff[8];
                flagsOut[flagV] = (a[7] != b[7]) && (diff[7] != a[7]);
            end
            aluOr: begin
                result = a | b;
                clearV = 1'b1;
            end
            aluAnd, aluTm: begin
                result = a & b;
                clearV = 1'b1;
            end
            aluTcm: begin
                result = ~a & b;
                clearV = 1'b1;
            end
            aluXor: begin
                result = a ^ b;
                clearV = 1'b1;
            end
            aluInc: begin
                result = a + 8'd1;
                flagsOut[flagV] = (a == 8'h7F);
            end
            aluDec: begin
                result = a - 8'd1;
                flagsOut[flagV] = (a == 8'h80);
            end
            aluCom: begin
                result = ~a;
                clearV = 1'b1;
            end
            aluSwap: begin
                result = {a[3:0], a[7:4]};
            end
            aluClr: begin
                result = 8'h00;
                updateZs = 1'b0;
            end
            default: begin
                updateZs = 1'b0;
            end
        endcase
        if (clearV) begin
            flagsOut[flagV] = 1'b0;
        end
        if (updateZs) begin
            flagsOut[flagZ] = (result == 8'h00);
            flagsOut[flagS] = result[7];
        end
    end
endmodule

`default_nettype wire

//--- hw/z8RegisterFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "z8_cfg.svh"

module z8RegisterFile
    import z8Pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] readAddrA,
    input  logic [7:0] readAddrB,
    output logic [7:0] readDataA,
    output logic [7:0] readDataB,
    input  logic       writeEnable,
    input  logic [7:0] writeAddr,
    input  logic [7:0] writeData,
    input  logic       flagsEnable,
    input  logic [7:0] flagsValue,
    output logic [7:0] flags,
    output logic [7:0] port2
);
    localparam int indexWidth = $clog2(`Z8_REG_COUNT);
    localparam logic [7:0] flagMask = (8'h1 << flagC) | (8'h1 << flagZ)
                                    | (8'h1 << flagS) | (8'h1 << flagV);

    logic [7:0] regs [`Z8_REG_COUNT];
    logic [3:0] rp;
    logic [7:0] mappedA;
    logic [7:0] mappedB;
    logic [7:0] mappedW;

    // high nibble E selects a working register in the bank at rp
    function automatic logic [7:0] mapWorking(input logic [7:0] addr, input logic [3:0] bank);
        mapWorking = (addr[7:4] == 4'hE) ? {bank, addr[3:0]} : addr;
    endfunction

    function automatic logic [7:0] readValue(
        input logic [7:0] addr,
        input logic [7:0] general,
        input logic [7:0] flagsNow,
        input logic [3:0] bank
    );
        if (addr < `Z8_REG_COUNT) begin
            readValue = general;
        end else if (addr == `Z8_ADDR_FLAGS) begin
            readValue = flagsNow;
        end else if (addr == `Z8_ADDR_RP) begin
            readValue = {bank, 4'h0};
        end else begin
            readValue = 8'h00;
        end
    endfunction

    assign mappedA = mapWorking(readAddrA, rp);
    assign mappedB = mapWorking(readAddrB, rp);
    assign mappedW = mapWorking(writeAddr, rp);

    assign readDataA = readValue(mappedA, regs[mappedA[indexWidth-1:0]], flags, rp);
    assign readDataB = readValue(mappedB, regs[mappedB[indexWidth-1:0]], flags, rp);

    always_ff @(posedge clk) begin
        if (writeEnable && mappedW < `Z8_REG_COUNT) begin
            regs[mappedW[indexWidth-1:0]] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rp <= 4'h0;
            flags <= 8'h00;
            port2 <= 8'h00;
        end else begin
            if (flagsEnable) begin
                flags <= flagsValue & flagMask;
            end
            // later assignment wins, so a register write to FLAGS beats flagsEnable
            if (writeEnable) begin
                if (mappedW == `Z8_ADDR_FLAGS) begin
                    flags <= writeData & flagMask;
                end
                if (mappedW == `Z8_ADDR_RP) begin
                    rp <= writeData[7:4];
                end
                if (mappedW == `Z8_ADDR_PORT2) begin
                    port2 <= writeData;
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- hw/z8Control.sv
`timescale 1ns/100ps
`default_nettype none

`include "z8_cfg.svh"

module z8Control
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  memDataRead,
    output logic [15:0] memAddr,
    output logic        memStrobe,
    output logic [7:0]  readAddrA,
    output logic [7:0]  readAddrB,
    input  logic [7:0]  readDataA,
    input  logic [7:0]  readDataB,
    input  logic [7:0]  flags,
    output aluOpT       aluOp,
    output logic [7:0]  aluA,
    output logic [7:0]  aluB,
    input  logic [7:0]  aluResult,
    input  logic [7:0]  aluFlags,
    output logic        writeEnable,
    output logic [7:0]  writeAddr,
    output logic        flagsEnable,
    output logic [7:0]  flagsValue
);
    cpuStateT    state;
    cpuStateT    nextState;
    logic [15:0] pc;
    logic [7:0]  instr;
    logic [7:0]  second;
    logic [7:0]  third;

    logic [3:0]  instrH;
    logic [3:0]  instrL;
    logic        sizeOne;
    logic        sizeThree;
    logic        isLdImm;
    logic        isSrp;
    logic        isAluTwo;
    logic        isAluOne;
    logic        isIncR;
    logic        isJr;
    logic        isJp;
    logic        isCarryOp;
    logic        twoWrites;
    logic        condBase;
    logic        takeBranch;
    logic [15:0] relTarget;
    logic [7:0]  dstAddr;
    logic [7:0]  carryFlags;

    assign instrH = instr[7:4];
    assign instrL = instr[3:0];

    // size from the low nibble: columns E/F one byte, 4-7 and D three bytes
    assign sizeOne = instrL[3:1] == 3'b111;
    assign sizeThree = instrL[3:2] == 2'b01 || instrL == 4'hD;

    assign isLdImm = instrL == 4'hC;
    assign isSrp = instr == 8'h31;
    assign isAluTwo = instrL == 4'h2 && (!instrH[3] || instrH[3:1] == 3'b101);
    assign isAluOne = instrL == 4'h0 && (instrH == 4'h0 || instrH == 4'h6
                                        || instrH == 4'hB || instrH == 4'hF);
    assign isIncR = instrL == 4'hE;
    assign isJr = instrL == 4'hB;
    assign isJp = instrL == 4'hD;
    assign isCarryOp = instrL == 4'hF && (instrH == 4'hC || instrH == 4'hD || instrH == 4'hE);

    // cp, tcm and tm only touch the flags
    assign twoWrites = instrH[3:2] == 2'b00 || instrH[3:1] == 3'b010 || instrH == 4'hB;

    // conditions 8-F are the negation of 0-7
    always_comb begin
        case (instrH[2:0])
            3'd0: condBase = 1'b0;
            3'd1: condBase = flags[flagS] ^ flags[flagV];
            3'd2: condBase = (flags[flagS] ^ flags[flagV]) | flags[flagZ];
            3'd3: condBase = flags[flagC] | flags[flagZ];
            3'd4: condBase = flags[flagV];
            3'd5: condBase = flags[flagS];
            3'd6: condBase = flags[flagZ];
            default: condBase = flags[flagC];
        endcase
    end
    assign takeBranch = condBase ^ instrH[3];

    // pc already points past the jr
    assign relTarget = pc + {{8{second[7]}}, second};

    assign memAddr = pc;
    assign memStrobe = state == fetchInstr || (state == wait2 && !sizeOne) || state == wait3;

    always_comb begin
        if (isAluOne) begin
            dstAddr = second;
        end else if (isAluTwo) begin
            dstAddr = {4'hE, second[7:4]};
        end else begin
            dstAddr = {4'hE, instrH};
        end
    end

    assign readAddrA = dstAddr;
    assign readAddrB = {4'hE, second[3:0]};
    assign writeAddr = isSrp ? `Z8_ADDR_RP : dstAddr;

    always_comb begin
        if (isAluTwo) begin
            aluOp = aluOpT'({1'b1, instrH});
        end else if (isAluOne) begin
            aluOp = aluOpT'({1'b0, instrH});
        end else if (isIncR) begin
            aluOp = aluInc;
        end else begin
            aluOp = aluLd;
        end
    end

    // carry ops pass the flags through the alu
    always_comb begin
        if (isLdImm || isSrp) begin
            aluA = second;
        end else if (isCarryOp) begin
            aluA = flags;
        end else begin
            aluA = readDataA;
        end
    end
    assign aluB = readDataB;

    always_comb begin
        carryFlags = aluResult;
        case (instrH)
            4'hC: carryFlags[flagC] = 1'b0;
            4'hD: carryFlags[flagC] = 1'b1;
            default: carryFlags[flagC] = ~flags[flagC];
        endcase
    end

    assign writeEnable = (state == decode && (isLdImm || isSrp))
                       || state == aluOne
                       || (state == aluTwo && twoWrites);
    assign flagsEnable = (state == decode && isCarryOp) || state == aluOne || state == aluTwo;
    assign flagsValue = isCarryOp ? carryFlags : aluFlags;

    always_comb begin
        case (state)
            fetchInstr: nextState = readInstr;
            readInstr:  nextState = wait2;
            wait2:      nextState = sizeOne ? decode : read2;
            read2:      nextState = sizeThree ? wait3 : decode;
            wait3:      nextState = read3;
            read3:      nextState = decode;
            decode: begin
                if (isAluOne || isIncR) begin
                    nextState = aluOne;
                end else if (isAluTwo) begin
                    nextState = aluTwo;
                end else begin
                    nextState = fetchInstr;
                end
            end
            default:    nextState = fetchInstr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetchInstr;
            pc <= `Z8_RESET_PC;
        end else begin
            state <= nextState;
            case (state)
                readInstr, read2, read3: begin
                    pc <= pc + 16'd1;
                end
                decode: begin
                    if (takeBranch && isJr) begin
                        pc <= relTarget;
                    end else if (takeBranch && isJp) begin
                        pc <= {second, third};
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // instruction bytes arrive one cycle after their strobe
    always_ff @(posedge clk) begin
        case (state)
            readInstr: instr <= memDataRead;
            read2:     second <= memDataRead;
            read3:     third <= memDataRead;
            default: begin
            end
        endcase
    end
endmodule

`default_nettype wire

//--- hw/z8Core.sv
`timescale 1ns/100ps
`default_nettype none

module z8Core
    import z8Pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [15:0] memAddr,
    output logic        memStrobe,
    input  logic [7:0]  memDataRead,
    output logic [7:0]  port2
);
    logic [7:0] readAddrA;
    logic [7:0] readAddrB;
    logic [7:0] readDataA;
    logic [7:0] readDataB;
    logic [7:0] flags;
    aluOpT      aluOp;
    logic [7:0] aluA;
    logic [7:0] aluB;
    logic [7:0] aluResult;
    logic [7:0] aluFlags;
    logic       writeEnable;
    logic [7:0] writeAddr;
    logic       flagsEnable;
    logic [7:0] flagsValue;

    z8Control control (
        .clk(clk),
        .reset(reset),
        .memDataRead(memDataRead),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .flags(flags),
        .aluOp(aluOp),
        .aluA(aluA),
        .aluB(aluB),
        .aluResult(aluResult),
        .aluFlags(aluFlags),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .flagsEnable(flagsEnable),
        .flagsValue(flagsValue)
    );

    // alu result is the only register write data
    z8RegisterFile registerFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(aluResult),
        .flagsEnable(flagsEnable),
        .flagsValue(flagsValue),
        .flags(flags),
        .port2(port2)
    );

    z8Alu alu (
        .aluOp(aluOp),
        .a(aluA),
        .b(aluB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(aluFlags)
    );
endmodule

`default_nettype wire

//--- verification/z8Core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module z8CoreProperties
    import z8Pkg::*;
(
    input logic        clk,
    input logic        reset,
    input cpuStateT    state,
    input logic        memStrobe,
    input logic [15:0] memAddr
);
    resetState: assert property (@(posedge clk) reset |=> state == fetchInstr)
        else $error("control not in fetchInstr after reset");

    // the bus needs a free cycle for each response
    strobeGap: assert property (@(posedge clk) disable iff (reset) memStrobe |=> !memStrobe)
        else $error("memStrobe high in two consecutive cycles");

    // operand bytes follow the byte strobed two cycles before
    strobeAddr: assert property (@(posedge clk) disable iff (reset)
        memStrobe && (state == wait2 || state == wait3)
        |-> memAddr == $past(memAddr, 2) + 16'd1)
        else $error("operand strobe not at the address after the previous strobe");
endmodule

bind z8Control z8CoreProperties props (
    .clk(clk),
    .reset(reset),
    .state(state),
    .memStrobe(memStrobe),
    .memAddr(memAddr)
);

`default_nettype wire

//--- verification/z8Model.svh
`ifndef Z8_MODEL_SVH
`define Z8_MODEL_SVH

// instruction-level reference model, included inside the testbench module

function automatic logic [7:0] mapAddr(input logic [7:0] addr);
    mapAddr = (addr[7:4] == 4'hE) ? {mRp, addr[3:0]} : addr;
endfunction

function automatic logic [7:0] readReg(input logic [7:0] addr);
    logic [7:0] m;
    m = mapAddr(addr);
    if (m < `Z8_REG_COUNT) begin
        readReg = mRegs[m[6:0]];
    end else if (m == `Z8_ADDR_FLAGS) begin
        readReg = mFlags;
    end else if (m == `Z8_ADDR_RP) begin
        readReg = {mRp, 4'h0};
    end else begin
        readReg = 8'h00;
    end
endfunction

task automatic writeReg(input logic [7:0] addr, input logic [7:0] value);
    logic [7:0] m;
    m = mapAddr(addr);
    if (m < `Z8_REG_COUNT) begin
        mRegs[m[6:0]] = value;
    end
    if (m == `Z8_ADDR_PORT2) begin
        // only changed values are visible on the port
        if (value != mPort2) begin
            port2Seq.push_back(value);
        end
        mPort2 = value;
    end
    if (m == `Z8_ADDR_RP) begin
        mRp = value[7:4];
    end
    if (m == `Z8_ADDR_FLAGS) begin
        mFlags = value & 8'hF0;
    end
endtask

task automatic setZs(input logic [7:0] res);
    mFlags[6] = (res == 8'h00);
    mFlags[5] = res[7];
endtask

// C=7 Z=6 S=5 V=4, codes 8-F negate 0-7
function automatic logic condTrue(input logic [3:0] cc);
    logic c;
    logic z;
    logic s;
    logic v;
    logic base;
    c = mFlags[7];
    z = mFlags[6];
    s = mFlags[5];
    v = mFlags[4];
    case (cc[2:0])
        3'd0: base = 1'b0;
        3'd1: base = s ^ v;
        3'd2: base = (s ^ v) | z;
        3'd3: base = c | z;
        3'd4: base = v;
        3'd5: base = s;
        3'd6: base = z;
        default: base = c;
    endcase
    condTrue = base ^ cc[3];
endfunction

task automatic twoOperand(input logic [3:0] hi, input logic [7:0] b1);
    logic [7:0] a;
    logic [7:0] bb;
    logic [7:0] res;
    int full;
    int c;
    a = readReg({4'hE, b1[7:4]});
    bb = readReg({4'hE, b1[3:0]});
    c = mFlags[7];
    case (hi)
        4'h0, 4'h1: begin
            full = int'(a) + int'(bb) + ((hi == 4'h1) ? c : 0);
            res = full[7:0];
            mFlags[7] = full > 255;
            mFlags[4] = (a[7] == bb[7]) && (res[7] != a[7]);
        end
        4'h2, 4'h3, 4'hA: begin
            full = int'(a) - int'(bb) - ((hi == 4'h3) ? c : 0);
            res = full[7:0];
            mFlags[7] = full < 0;
            mFlags[4] = (a[7] != bb[7]) && (res[7] != a[7]);
        end
        default: begin
            case (hi)
                4'h4: res = a | bb;
                4'h6: res = ~a & bb;
                4'hB: res = a ^ bb;
                default: res = a & bb;
            endcase
            mFlags[4] = 1'b0;
        end
    endcase
    setZs(res);
    // cp, tcm and tm leave the destination alone
    if (hi <= 4'h5 || hi == 4'hB) begin
        writeReg({4'hE, b1[7:4]}, res);
    end
endtask

task automatic oneOperand(input logic [3:0] hi, input logic [7:0] addr);
    logic [7:0] a;
    logic [7:0] res;
    a = readReg(addr);
    case (hi)
        4'h0: begin
            res = a - 8'd1;
            mFlags[4] = (a == 8'h80);
            setZs(res);
        end
        4'h6: begin
            res = ~a;
            mFlags[4] = 1'b0;
            setZs(res);
        end
        4'hB: res = 8'h00;
        default: begin
            res = {a[3:0], a[7:4]};
            setZs(res);
        end
    endcase
    writeReg(addr, res);
endtask

task automatic runModel();
    logic [15:0] pc;
    logic [15:0] next;
    logic [7:0] op;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] a;
    int size;
    int steps;
    bit done;
    fetchTrace.delete();
    port2Seq.delete();
    mRp = 4'h0;
    mFlags = 8'h00;
    mPort2 = 8'h00;
    pc = `Z8_RESET_PC;
    done = 0;
    steps = 0;
    while (!done) begin
        assert (steps < 400) else reportFailure("reference model never reached the self-loop");
        op = mem[pc[9:0]];
        b1 = mem[10'(pc + 16'd1)];
        b2 = mem[10'(pc + 16'd2)];
        if (op[3:1] == 3'b111) begin
            size = 1;
        end else if (op[3:0] inside {4'h4, 4'h5, 4'h6, 4'h7, 4'hD}) begin
            size = 3;
        end else begin
            size = 2;
        end
        for (int k = 0; k < size; k++) begin
            fetchTrace.push_back(pc + 16'(k));
        end
        next = pc + 16'(size);
        case (op[3:0])
            4'hC: writeReg({4'hE, op[7:4]}, b1);
            4'h1: writeReg(`Z8_ADDR_RP, b1);
            4'h2: twoOperand(op[7:4], b1);
            4'h0: oneOperand(op[7:4], b1);
            4'hE: begin
                a = readReg({4'hE, op[7:4]});
                mFlags[4] = (a == 8'h7F);
                setZs(a + 8'd1);
                writeReg({4'hE, op[7:4]}, a + 8'd1);
            end
            4'hB: begin
                if (op == 8'h8B && b1 == 8'hFE) begin
                    done = 1;
                    loopAddr = pc;
                end else if (condTrue(op[7:4])) begin
                    next = next + {{8{b1[7]}}, b1};
                end
            end
            4'hD: begin
                if (condTrue(op[7:4])) begin
                    next = {b1, b2};
                end
            end
            default: begin
                case (op[7:4])
                    4'hC: mFlags[7] = 1'b0;
                    4'hD: mFlags[7] = 1'b1;
                    4'hE: mFlags[7] = ~mFlags[7];
                    default: begin
                    end
                endcase
            end
        endcase
        pc = next;
        steps++;
    end
endtask

`endif

//--- verification/z8CoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "z8_cfg.svh"

module z8CoreTb;
    localparam int programCount = 8;
    localparam int instrCount = 24;
    localparam int timeoutCycles = 4000;
    localparam int memSize = 1024;

    logic        clk;
    logic        reset;
    logic [15:0] memAddr;
    logic        memStrobe;
    logic [7:0]  memDataRead;
    logic [7:0]  port2;

    logic [31:0] lfsrState;
    logic [7:0]  mem [memSize];

    // model state and expectations
    logic [7:0]  mRegs [`Z8_REG_COUNT];
    logic [3:0]  mRp;
    logic [7:0]  mFlags;
    logic [7:0]  mPort2;
    logic [15:0] fetchTrace [$];
    logic [7:0]  port2Seq [$];
    logic [15:0] loopAddr;

    bit          checking;
    bit          seenFirst;
    int          traceIdx;
    int          port2Idx;
    int          errorCount;
    logic        lastStrobe;
    logic [15:0] lastAddr;
    logic [7:0]  lastPort2;

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    `include "z8Model.svh"

    z8Core uut (
        .clk(clk),
        .reset(reset),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .memDataRead(memDataRead),
        .port2(port2)
    );

    always #4 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic nextBit();
        nextBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (nextBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
    endfunction

    function automatic logic [7:0] randBits(input int n);
        randBits = 8'h00;
        for (int i = 0; i < n; i++) begin
            randBits = {randBits[6:0], nextBit()};
        end
    endfunction

    function automatic logic [3:0] twoOpNibble(input int k);
        twoOpNibble = (k < 8) ? 4'(k) : ((k == 8) ? 4'hA : 4'hB);
    endfunction

    task automatic emitByte(inout int addr, input logic [7:0] value);
        mem[addr] = value;
        addr++;
    endtask

    // jumpKind 1 is jr, 2 is jp; displacement bytes get patched later
    task automatic genInstr(
        input  bit         allowJump,
        output logic [7:0] b0,
        output logic [7:0] b1,
        output logic [7:0] b2,
        output int         size,
        output int         jumpKind
    );
        logic [7:0] pick;
        logic [7:0] t;
        logic [7:0] u;
        logic [7:0] v;
        pick = randBits(4);
        b1 = 8'h00;
        b2 = 8'h00;
        size = 2;
        jumpKind = 0;
        if (!allowJump && pick inside {8, 9, 10, 15}) begin
            pick = 14;
        end
        t = randBits(4);
        case (pick)
            0, 1, 14: begin
                b0 = {(pick == 14) ? 4'h2 : t[3:0], 4'hC};
                b1 = randBits(8);
            end
            2: begin
                b0 = 8'h31;
                b1 = randBits(6);
            end
            6: begin
                u = randBits(2);
                b0 = {(u == 0) ? 4'h0 : (u == 1) ? 4'h6 : (u == 2) ? 4'hB : 4'hF, 4'h0};
                u = randBits(2);
                if (u == 0) begin
                    b1 = `Z8_ADDR_PORT2;
                end else if (u == 1) begin
                    b1 = {4'hE, t[3:0]};
                end else begin
                    b1 = randBits(6);
                end
            end
            7: begin
                b0 = {t[3:0], 4'hE};
                size = 1;
            end
            8, 9, 15: begin
                b0 = {t[3:0], 4'hB};
                jumpKind = 1;
            end
            10: begin
                b0 = {t[3:0], 4'hD};
                size = 3;
                jumpKind = 2;
            end
            11: begin
                b0 = {2'b11, t[1:0], 4'hF};
                size = 1;
            end
            default: begin
                u = randBits(1);
                b0 = {twoOpNibble(int'(t) % 10), 4'h2};
                v = u[0] ? 8'h02 : randBits(4);
                u = randBits(4);
                b1 = {v[3:0], u[3:0]};
            end
        endcase
    endtask

    task automatic buildProgram();
        int addr;
        int start;
        int patchAt;
        int patchKind;
        int size;
        int jumpKind;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [15:0] target;
        for (int i = 0; i < memSize; i++) begin
            mem[i] = 8'(i * 37 + (i >> 5));
        end
        addr = `Z8_RESET_PC;
        // banks 0-3 hold every register the programs touch
        for (int bank = 0; bank < 4; bank++) begin
            emitByte(addr, 8'h31);
            emitByte(addr, {4'(bank), 4'h0});
            for (int r = 0; r < 16; r++) begin
                emitByte(addr, {4'(r), 4'hC});
                emitByte(addr, randBits(8));
            end
        end
        patchAt = -1;
        patchKind = 0;
        for (int i = 0; i < instrCount; i++) begin
            genInstr(i < instrCount - 1, b0, b1, b2, size, jumpKind);
            start = addr;
            emitByte(addr, b0);
            if (size > 1) begin
                emitByte(addr, b1);
            end
            if (size > 2) begin
                emitByte(addr, b2);
            end
            // previous jump skips exactly this instruction
            if (patchAt >= 0) begin
                if (patchKind == 1) begin
                    mem[patchAt] = 8'(size);
                end else begin
                    target = 16'(start + size);
                    mem[patchAt] = target[15:8];
                    mem[patchAt + 1] = target[7:0];
                end
                patchAt = -1;
            end
            if (jumpKind != 0) begin
                patchAt = start + 1;
                patchKind = jumpKind;
            end
        end
        emitByte(addr, 8'h8B);
        emitByte(addr, 8'hFE);
    endtask

    // outputs sampled before the edge updates them
    always @(posedge clk) begin
        if (checking && !reset) begin
            if (memStrobe) begin
                if (!seenFirst) begin
                    assert (memAddr == `Z8_RESET_PC) else reportFailure($sformatf(
                        "error at %0t: first strobe read %h", $time, memAddr));
                    seenFirst = 1;
                end
                if (traceIdx < fetchTrace.size()) begin
                    assert (memAddr == fetchTrace[traceIdx]) else reportFailure($sformatf(
                        "error at %0t: fetch %0d from %h, expected %h",
                        $time, traceIdx, memAddr, fetchTrace[traceIdx]));
                    traceIdx++;
                end else begin
                    assert (memAddr == loopAddr || memAddr == loopAddr + 16'd1)
                        else reportFailure($sformatf(
                        "error at %0t: fetch from %h left the self-loop at %h",
                        $time, memAddr, loopAddr));
                end
            end
            if (port2 !== lastPort2) begin
                assert (port2Idx < port2Seq.size()) else reportFailure($sformatf(
                    "error at %0t: port2 changed to %h, no change expected", $time, port2));
                assert (port2 == port2Seq[port2Idx]) else reportFailure($sformatf(
                    "error at %0t: port2 is %h, expected %h", $time, port2,
                    port2Seq[port2Idx]));
                port2Idx++;
                lastPort2 = port2;
            end
        end
        lastStrobe = memStrobe;
        lastAddr = memAddr;
    end

    // one-cycle read response
    always @(negedge clk) begin
        memDataRead = lastStrobe ? mem[lastAddr[9:0]] : 8'h00;
    end

    initial begin
        int cycles;
        clk = 1'b0;
        reset = 1'b1;
        memDataRead = 8'h00;
        lfsrState = 32'h6f97;
        checking = 0;
        seenFirst = 0;
        errorCount = 0;
        traceIdx = 0;
        port2Idx = 0;
        lastStrobe = 1'b0;
        lastAddr = 16'h0000;
        lastPort2 = 8'h00;
        for (int p = 0; p < programCount; p++) begin
            @(negedge clk);
            reset = 1'b1;
            checking = 0;
            buildProgram();
            runModel();
            repeat (3) @(negedge clk);
            traceIdx = 0;
            port2Idx = 0;
            lastPort2 = 8'h00;
            seenFirst = 0;
            checking = 1;
            reset = 1'b0;
            cycles = 0;
            while (traceIdx < fetchTrace.size() && cycles < timeoutCycles) begin
                @(negedge clk);
                cycles++;
            end
            assert (traceIdx == fetchTrace.size()) else reportFailure($sformatf(
                "timeout: program %0d did not reach its self-loop in %0d cycles",
                p, timeoutCycles));
            assert (port2 == mPort2) else reportFailure($sformatf(
                "error at %0t: final port2 %h, expected %h", $time, port2, mPort2));
            assert (port2Idx == port2Seq.size()) else reportFailure($sformatf(
                "error at %0t: saw %0d port2 changes, expected %0d",
                $time, port2Idx, port2Seq.size()));
        end
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

//--- all.f
+incdir+hw
+incdir+verification
hw/z8Pkg.sv
hw/z8Alu.sv
hw/z8RegisterFile.sv
hw/z8Control.sv
hw/z8Core.sv
verification/z8Core_properties.sv
verification/z8CoreTb.sv

//--- Bender.yml
package:
  name: z8core

sources:
  - include_dirs:
      - hw
    files:
      - hw/z8Pkg.sv
      - hw/z8Alu.sv
      - hw/z8RegisterFile.sv
      - hw/z8Control.sv
      - hw/z8Core.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/z8Core_properties.sv
      - verification/z8CoreTb.sv
